// File: backendPkg.sv
`default_nettype none

package backendPkg;

    localparam int ARCH_REGS  = 8;
    localparam int ARCH_W     = $clog2(ARCH_REGS);
    localparam int DATA_W     = 16;
    localparam int INST_W     = 16;
    localparam int IMM_W      = 7;

    // struct field sizes, module parameters must stay within these
    localparam int PHYS_TAG_W = 5;
    localparam int ROB_IDX_W  = 4;

    // encoding matches the 3-bit opcode field
    typedef enum logic [2:0] {
        ALU_ADD     = 3'd0,
        ALU_SUB     = 3'd1,
        ALU_AND     = 3'd2,
        ALU_OR      = 3'd3,
        ALU_XOR     = 3'd4,
        ALU_ADDI    = 3'd5,
        ALU_LI      = 3'd6,
        ALU_ILLEGAL = 3'd7
    } aluOpE;

    // inst: [15:13] opcode, [12:10] rd, [9:7] rs1, [6:4] rs2 or [6:0] imm
    typedef struct packed {
        logic              valid;
        logic [INST_W-1:0] inst;
    } fetchPktS;

    typedef struct packed {
        logic              valid;
        aluOpE             op;
        logic [ARCH_W-1:0] rd;
        logic [ARCH_W-1:0] rs1;
        logic [ARCH_W-1:0] rs2;
        logic [DATA_W-1:0] imm;
        logic              useRs1;
        logic              useRs2;
        logic              we;
    } decPktS;

    typedef struct packed {
        decPktS                dec;
        logic [PHYS_TAG_W-1:0] pd;
        logic [PHYS_TAG_W-1:0] oldPd;
        logic [PHYS_TAG_W-1:0] ps1;
        logic [PHYS_TAG_W-1:0] ps2;
        logic [ROB_IDX_W-1:0]  robIdx;
    } renPktS;

    typedef struct packed {
        logic                  valid;
        logic [PHYS_TAG_W-1:0] pd;
        logic [ROB_IDX_W-1:0]  robIdx;
        logic [DATA_W-1:0]     data;
    } wbPktS;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ARCH_W-1:0] rd;
        logic [DATA_W-1:0] data;
    } commitPktS;

endpackage

`default_nettype wire

// File: decode.sv
`default_nettype none

module decode (
    input  logic                 clk,
    input  logic                 rstN,
    input  backendPkg::fetchPktS fetch,
    output backendPkg::decPktS   dec
);
    logic                          instValid;
    logic [backendPkg::INST_W-1:0] instWord;
    logic [2:0]                    opcode;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instValid <= 1'b0;
        end else begin
            instValid <= fetch.valid;
        end
        if (fetch.valid) begin
            instWord <= fetch.inst;
        end
    end

    assign opcode = instWord[15:13];

    always_comb begin
        dec.valid = instValid;
        dec.rd    = instWord[12:10];
        dec.rs1   = instWord[9:7];
        dec.rs2   = instWord[6:4];
        dec.imm   = {{(backendPkg::DATA_W - backendPkg::IMM_W){instWord[6]}}, instWord[6:0]};
        case (opcode)
            3'd0:    dec.op = backendPkg::ALU_ADD;
            3'd1:    dec.op = backendPkg::ALU_SUB;
            3'd2:    dec.op = backendPkg::ALU_AND;
            3'd3:    dec.op = backendPkg::ALU_OR;
            3'd4:    dec.op = backendPkg::ALU_XOR;
            3'd5:    dec.op = backendPkg::ALU_ADDI;
            3'd6:    dec.op = backendPkg::ALU_LI;
            default: dec.op = backendPkg::ALU_ILLEGAL;
        endcase
        // reg-reg ops read both, addi only rs1, li nothing
        dec.useRs1 = (opcode <= 3'd5);
        dec.useRs2 = (opcode <= 3'd4);
        dec.we     = (opcode != 3'd7);
    end

endmodule

`default_nettype wire

// File: rename.sv
`default_nettype none

module rename #(
    parameter int PHYS_REGS = 16,
    parameter int ROB_DEPTH = 8,
    parameter int IQ_DEPTH  = 4
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  backendPkg::decPktS                  dec,
    input  logic [backendPkg::ROB_IDX_W-1:0]    robTail,
    input  logic [$clog2(ROB_DEPTH+1)-1:0]      robFree,
    input  logic [$clog2(IQ_DEPTH+1)-1:0]       iqFree,
    input  logic                                freeValid,
    input  logic [backendPkg::PHYS_TAG_W-1:0]   freeTag,
    output backendPkg::renPktS                  ren,
    output logic                                stall
);
    localparam int FL_DEPTH = PHYS_REGS - backendPkg::ARCH_REGS;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);
    localparam int FL_CNT_W = $clog2(FL_DEPTH + 1);

    logic [backendPkg::PHYS_TAG_W-1:0] mapTable [backendPkg::ARCH_REGS];
    logic [backendPkg::PHYS_TAG_W-1:0] freeList [FL_DEPTH];
    logic [FL_PTR_W-1:0]               flHead;
    logic [FL_PTR_W-1:0]               flTail;
    logic [FL_CNT_W-1:0]               flCount;
    logic                              allocate;

    function automatic logic [FL_PTR_W-1:0] flNext(input logic [FL_PTR_W-1:0] ptr);
        return (ptr == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // only ops that write a register take a new tag
    assign allocate = dec.valid && dec.we;

    always_comb begin
        ren.dec    = dec;
        ren.ps1    = mapTable[dec.rs1];
        ren.ps2    = mapTable[dec.rs2];
        ren.oldPd  = mapTable[dec.rd];
        ren.pd     = allocate ? freeList[flHead] : '0;
        ren.robIdx = robTail;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < backendPkg::ARCH_REGS; i++) begin
                mapTable[i] <= backendPkg::PHYS_TAG_W'(i);
            end
            // upper tags start out free
            for (int i = 0; i < FL_DEPTH; i++) begin
                freeList[i] <= backendPkg::PHYS_TAG_W'(backendPkg::ARCH_REGS + i);
            end
            flHead  <= '0;
            flTail  <= '0;
            flCount <= FL_CNT_W'(FL_DEPTH);
        end else begin
            if (allocate) begin
                mapTable[dec.rd] <= freeList[flHead];
                flHead           <= flNext(flHead);
            end
            if (freeValid) begin
                freeList[flTail] <= freeTag;
                flTail           <= flNext(flTail);
            end
            flCount <= flCount + FL_CNT_W'(freeValid) - FL_CNT_W'(allocate);
        end
    end

    // margin of two covers the op sitting in decode
    assign stall = (flCount < 2) || (robFree < 2) || (iqFree < 2);

endmodule

`default_nettype wire

// File: rob.sv
`default_nettype none

module rob #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  backendPkg::renPktS                ren,
    input  backendPkg::wbPktS                 wb,
    output logic [backendPkg::ROB_IDX_W-1:0]  robTail,
    output logic [$clog2(ROB_DEPTH+1)-1:0]    robFree,
    output logic                              freeValid,
    output logic [backendPkg::PHYS_TAG_W-1:0] freeTag,
    output backendPkg::commitPktS             commit
);
    localparam int PTR_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    logic [backendPkg::ARCH_W-1:0]     rdQ    [ROB_DEPTH];
    logic [backendPkg::PHYS_TAG_W-1:0] oldPdQ [ROB_DEPTH];
    logic [backendPkg::DATA_W-1:0]     dataQ  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]              weQ;
    logic [ROB_DEPTH-1:0]              doneQ;
    logic [PTR_W-1:0]                  head;
    logic [PTR_W-1:0]                  tail;
    logic [CNT_W-1:0]                  count;
    logic [PTR_W-1:0]                  wbIdx;
    logic                              alloc;
    logic                              headHit;
    logic                              retire;
    logic [backendPkg::DATA_W-1:0]     headData;

    function automatic logic [PTR_W-1:0] robNext(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign alloc   = ren.dec.valid;
    assign wbIdx   = wb.robIdx[PTR_W-1:0];
    assign robTail = backendPkg::ROB_IDX_W'(tail);
    assign robFree = CNT_W'(ROB_DEPTH) - count;

    // writeback to the head retires it without waiting for doneQ
    assign headHit = wb.valid && (wbIdx == head);
    assign retire  = (count != '0) && (doneQ[head] || headHit);

    always_comb begin
        if (headHit) begin
            headData = wb.data;
        end else if (weQ[head]) begin
            headData = dataQ[head];
        end else begin
            headData = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            freeValid <= 1'b0;
            commit    <= '0;
        end else begin
            if (alloc) begin
                tail <= robNext(tail);
            end
            if (retire) begin
                head <= robNext(head);
            end
            count     <= count + CNT_W'(alloc) - CNT_W'(retire);
            freeValid <= retire && weQ[head];
            commit    <= '{valid: retire, we: weQ[head], rd: rdQ[head], data: headData};
        end
        freeTag <= oldPdQ[head];
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            rdQ[tail]    <= ren.dec.rd;
            oldPdQ[tail] <= ren.oldPd;
            weQ[tail]    <= ren.dec.we;
            // illegal ops never issue, so they are done on entry
            doneQ[tail]  <= !ren.dec.we;
        end
        if (wb.valid) begin
            doneQ[wbIdx] <= 1'b1;
            dataQ[wbIdx] <= wb.data;
        end
    end

endmodule

`default_nettype wire

// File: intIssueQueue.sv
`default_nettype none

module intIssueQueue #(
    parameter int PHYS_REGS = 16,
    parameter int IQ_DEPTH  = 4
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  backendPkg::renPktS            ren,
    input  backendPkg::wbPktS             wb,
    output logic [$clog2(IQ_DEPTH+1)-1:0] iqFree,
    output logic                          issueValid,
    output backendPkg::renPktS            issue
);
    localparam int CNT_W  = $clog2(IQ_DEPTH + 1);
    localparam int SEL_W  = $clog2(IQ_DEPTH);
    localparam int PHYS_W = $clog2(PHYS_REGS);

    backendPkg::renPktS slots  [IQ_DEPTH];
    backendPkg::renPktS nSlots [IQ_DEPTH];
    logic [IQ_DEPTH-1:0]  rdy1;
    logic [IQ_DEPTH-1:0]  rdy2;
    logic [IQ_DEPTH-1:0]  nRdy1;
    logic [IQ_DEPTH-1:0]  nRdy2;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     nCount;
    logic [PHYS_REGS-1:0] busy;
    logic                 enq;
    logic                 selValid;
    logic [SEL_W-1:0]     selIdx;

    function automatic logic wbHit(input backendPkg::wbPktS bus,
                                   input logic [backendPkg::PHYS_TAG_W-1:0] tag);
        return bus.valid && (bus.pd == tag);
    endfunction

    // illegal ops skip the queue
    assign enq    = ren.dec.valid && ren.dec.we;
    assign iqFree = CNT_W'(IQ_DEPTH) - count;

    // slot 0 is oldest, take the lowest ready slot
    always_comb begin
        selValid = 1'b0;
        selIdx   = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if ((CNT_W'(i) < count) &&
                (rdy1[i] || wbHit(wb, slots[i].ps1)) &&
                (rdy2[i] || wbHit(wb, slots[i].ps2))) begin
                selValid = 1'b1;
                selIdx   = SEL_W'(i);
            end
        end
    end

    always_comb begin
        nSlots = slots;
        nRdy1  = rdy1;
        nRdy2  = rdy2;
        nCount = count;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (wbHit(wb, slots[i].ps1)) begin
                nRdy1[i] = 1'b1;
            end
            if (wbHit(wb, slots[i].ps2)) begin
                nRdy2[i] = 1'b1;
            end
        end
        // close the gap left by the issued slot
        if (selValid) begin
            for (int i = 0; i < IQ_DEPTH - 1; i++) begin
                if (i >= int'(selIdx)) begin
                    nSlots[i] = nSlots[i+1];
                    nRdy1[i]  = nRdy1[i+1];
                    nRdy2[i]  = nRdy2[i+1];
                end
            end
            nCount = count - 1'b1;
        end
        if (enq) begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (CNT_W'(i) == nCount) begin
                    nSlots[i] = ren;
                    nRdy1[i]  = !ren.dec.useRs1 || !busy[ren.ps1[PHYS_W-1:0]] ||
                                wbHit(wb, ren.ps1);
                    nRdy2[i]  = !ren.dec.useRs2 || !busy[ren.ps2[PHYS_W-1:0]] ||
                                wbHit(wb, ren.ps2);
                end
            end
            nCount = nCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count      <= '0;
            rdy1       <= '0;
            rdy2       <= '0;
            busy       <= '0;
            issueValid <= 1'b0;
        end else begin
            count      <= nCount;
            rdy1       <= nRdy1;
            rdy2       <= nRdy2;
            issueValid <= selValid;
            if (wb.valid) begin
                busy[wb.pd[PHYS_W-1:0]] <= 1'b0;
            end
            if (enq) begin
                busy[ren.pd[PHYS_W-1:0]] <= 1'b1;
            end
        end
        slots <= nSlots;
        issue <= slots[selIdx];
    end

endmodule

`default_nettype wire

// File: execute.sv
`default_nettype none

module execute #(
    parameter int PHYS_REGS = 16
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               issueValid,
    input  backendPkg::renPktS issue,
    output backendPkg::wbPktS  wb
);
    localparam int PHYS_W = $clog2(PHYS_REGS);

    logic [backendPkg::DATA_W-1:0] regFile [PHYS_REGS];
    logic [backendPkg::DATA_W-1:0] src1;
    logic [backendPkg::DATA_W-1:0] src2;
    logic [backendPkg::DATA_W-1:0] result;

    // forward the value being written this cycle
    assign src1 = (wb.valid && wb.pd == issue.ps1) ? wb.data : regFile[issue.ps1[PHYS_W-1:0]];
    assign src2 = (wb.valid && wb.pd == issue.ps2) ? wb.data : regFile[issue.ps2[PHYS_W-1:0]];

    always_comb begin
        case (issue.dec.op)
            backendPkg::ALU_ADD:  result = src1 + src2;
            backendPkg::ALU_SUB:  result = src1 - src2;
            backendPkg::ALU_AND:  result = src1 & src2;
            backendPkg::ALU_OR:   result = src1 | src2;
            backendPkg::ALU_XOR:  result = src1 ^ src2;
            backendPkg::ALU_ADDI: result = src1 + issue.dec.imm;
            backendPkg::ALU_LI:   result = issue.dec.imm;
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb.valid <= 1'b0;
            // all tags read as zero out of reset
            for (int i = 0; i < PHYS_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            wb.valid <= issueValid;
            if (wb.valid) begin
                regFile[wb.pd[PHYS_W-1:0]] <= wb.data;
            end
        end
        wb.pd     <= issue.pd;
        wb.robIdx <= issue.robIdx;
        wb.data   <= result;
    end

endmodule

`default_nettype wire

// File: backend.sv
`default_nettype none

module backend #(
    parameter int PHYS_REGS = 16,
    parameter int ROB_DEPTH = 8,
    parameter int IQ_DEPTH  = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  backendPkg::fetchPktS  fetch,
    output logic                  stall,
    output backendPkg::commitPktS commit
);
    backendPkg::decPktS                dec;
    backendPkg::renPktS                ren;
    backendPkg::renPktS                issue;
    backendPkg::wbPktS                 wb;
    logic [backendPkg::ROB_IDX_W-1:0]  robTail;
    logic [$clog2(ROB_DEPTH+1)-1:0]    robFree;
    logic [$clog2(IQ_DEPTH+1)-1:0]     iqFree;
    logic                              freeValid;
    logic [backendPkg::PHYS_TAG_W-1:0] freeTag;
    logic                              issueValid;

    decode decodeI (.*);

    // stall back to fetch comes out of rename
    rename #(
        .PHYS_REGS(PHYS_REGS),
        .ROB_DEPTH(ROB_DEPTH),
        .IQ_DEPTH (IQ_DEPTH)
    ) renameI (.*);

    rob #(
        .ROB_DEPTH(ROB_DEPTH)
    ) robI (.*);

    intIssueQueue #(
        .PHYS_REGS(PHYS_REGS),
        .IQ_DEPTH (IQ_DEPTH)
    ) intIqI (.*);

    // wb doubles as the wakeup broadcast
    execute #(
        .PHYS_REGS(PHYS_REGS)
    ) executeI (.*);

endmodule

`default_nettype wire

// File: backend_asserts.sv
`default_nettype none

module backendAsserts (
    input logic clk,
    input logic rstN,
    input logic fetchValid,
    input logic stall,
    input logic commitValid,
    input logic wbValid,
    input logic issueValid
);
    timeunit 1ns;
    timeprecision 1ps;

    // fetch holds off while stall is up
    noStrobeInStall: assert property (@(posedge clk) disable iff (!rstN)
        !(fetchValid && stall))
        else $error("fetch strobe arrived while stall was high");

    commitQuietInReset: assert property (@(posedge clk) !rstN |=> !commitValid)
        else $error("commit valid seen during or just after reset");

    // wb is the registered issue strobe
    wbFollowsIssue: assert property (@(posedge clk) disable iff (!rstN)
        wbValid |-> $past(issueValid))
        else $error("writeback valid without an issue strobe the cycle before");

endmodule

bind backend backendAsserts assertsI (
    .clk        (clk),
    .rstN       (rstN),
    .fetchValid (fetch.valid),
    .stall      (stall),
    .commitValid(commit.valid),
    .wbValid    (wb.valid),
    .issueValid (issueValid)
);

`default_nettype wire

// File: backendTb.sv
`default_nettype none

module backendTb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [2:0]  test;
        logic [15:0] inst;
        logic [3:0]  gap;
    } stepS;

    typedef struct packed {
        logic [2:0]            test;
        backendPkg::commitPktS pkt;
    } expS;

    logic                          clk = 1'b0;
    logic                          rstN;
    backendPkg::fetchPktS          fetch;
    logic                          stall;
    backendPkg::commitPktS         commit;

    stepS                          progQ [$];
    expS                           expQ  [$];
    logic [backendPkg::DATA_W-1:0] archRegs [backendPkg::ARCH_REGS];
    string                         testNames [6] = '{"resetRead", "independentOps", "rawChain",
                                                     "wawWar", "randomLong", "illegalOp"};
    integer                        seed = 32'h4954_349a;
    int                            errorCount = 0;
    int                            checkCount = 0;
    int                            cycleCount = 0;
    int                            cycleLimit = 0;

    backend #(
        .PHYS_REGS(16),
        .ROB_DEPTH(8),
        .IQ_DEPTH (4)
    ) uut (.*);

    always #50 clk = ~clk;

    function automatic logic [15:0] rType(input backendPkg::aluOpE op, input int rd,
                                          input int rs1, input int rs2);
        return {op, 3'(rd), 3'(rs1), 3'(rs2), 4'b0000};
    endfunction

    function automatic logic [15:0] iType(input backendPkg::aluOpE op, input int rd,
                                          input int rs1, input int imm);
        return {op, 3'(rd), 3'(rs1), 7'(imm)};
    endfunction

    task automatic addStep(input int test, input logic [15:0] inst, input int gap);
        progQ.push_back('{test: 3'(test), inst: inst, gap: 4'(gap)});
    endtask

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Error: %s %s expected %0h actual %0h", testName, field, expected, actual);
        end
    endtask

    // in-order reference for one instruction word
    task automatic modelStep(input logic [15:0] inst, input logic [2:0] test);
        logic [2:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] res;
        expS         e;
        op  = inst[15:13];
        a   = archRegs[inst[9:7]];
        b   = archRegs[inst[6:4]];
        imm = {{9{inst[6]}}, inst[6:0]};
        case (op)
            3'd0:    res = a + b;
            3'd1:    res = a - b;
            3'd2:    res = a & b;
            3'd3:    res = a | b;
            3'd4:    res = a ^ b;
            3'd5:    res = a + imm;
            3'd6:    res = imm;
            default: res = 16'h0000;
        endcase
        e.test      = test;
        e.pkt.valid = 1'b1;
        e.pkt.we    = (op != 3'd7);
        e.pkt.rd    = inst[12:10];
        e.pkt.data  = res;
        if (e.pkt.we) begin
            archRegs[inst[12:10]] = res;
        end
        expQ.push_back(e);
    endtask

    task automatic loadPrograms();
        logic [31:0] r;
        logic [31:0] g;
        for (int i = 0; i < 8; i++) begin
            addStep(0, rType(backendPkg::ALU_ADD, i, i, i), 0);
        end
        addStep(1, iType(backendPkg::ALU_LI, 1, 0, 25), 1);
        addStep(1, iType(backendPkg::ALU_LI, 2, 0, -6), 1);
        addStep(1, iType(backendPkg::ALU_ADDI, 3, 0, 63), 1);
        addStep(1, iType(backendPkg::ALU_LI, 4, 0, -64), 1);
        addStep(1, rType(backendPkg::ALU_ADD, 5, 1, 2), 1);
        addStep(1, rType(backendPkg::ALU_SUB, 6, 1, 2), 1);
        addStep(1, rType(backendPkg::ALU_AND, 7, 2, 4), 1);
        addStep(1, rType(backendPkg::ALU_OR, 0, 1, 4), 1);
        addStep(1, rType(backendPkg::ALU_XOR, 5, 2, 3), 1);
        // li r6 and addi r6 can slip ahead of the chain
        addStep(2, iType(backendPkg::ALU_LI, 1, 0, 3), 0);
        addStep(2, rType(backendPkg::ALU_ADD, 2, 1, 1), 0);
        addStep(2, iType(backendPkg::ALU_LI, 6, 0, 9), 0);
        addStep(2, rType(backendPkg::ALU_ADD, 3, 2, 1), 0);
        addStep(2, iType(backendPkg::ALU_ADDI, 6, 6, -2), 0);
        addStep(2, rType(backendPkg::ALU_XOR, 4, 3, 2), 0);
        addStep(2, rType(backendPkg::ALU_ADD, 1, 4, 3), 0);
        addStep(2, rType(backendPkg::ALU_SUB, 5, 1, 6), 0);
        addStep(3, iType(backendPkg::ALU_LI, 2, 0, 7), 0);
        addStep(3, iType(backendPkg::ALU_LI, 2, 0, 9), 0);
        addStep(3, rType(backendPkg::ALU_ADD, 3, 2, 2), 0);
        addStep(3, iType(backendPkg::ALU_LI, 2, 0, 1), 0);
        addStep(3, rType(backendPkg::ALU_SUB, 4, 3, 2), 0);
        addStep(3, rType(backendPkg::ALU_ADD, 3, 3, 3), 0);
        addStep(3, rType(backendPkg::ALU_OR, 3, 4, 3), 0);
        addStep(3, iType(backendPkg::ALU_ADDI, 2, 2, 5), 0);
        // mostly bursts, with the odd gap
        for (int i = 0; i < 160; i++) begin
            r = $random(seed);
            g = $random(seed);
            addStep(4, {3'(r % 32'd7), r[12:0]}, (g[3:0] < 4'd11) ? 0 : int'(g[6:4]));
        end
        addStep(5, iType(backendPkg::ALU_LI, 4, 0, 33), 2);
        addStep(5, iType(backendPkg::ALU_ILLEGAL, 4, 4, 21), 2);
        addStep(5, rType(backendPkg::ALU_ADD, 5, 4, 0), 2);
        addStep(5, iType(backendPkg::ALU_ADDI, 4, 4, 1), 2);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, %0d commits still outstanding",
                     cycleCount, expQ.size());
            $display("Test failures found");
            $finish;
        end
    end

    // commit monitor, sampled away from the rising edge
    always @(negedge clk) begin
        expS e;
        if (rstN && commit.valid) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("Commit of r%0d arrived with no instruction left to retire", commit.rd);
            end else begin
                e = expQ.pop_front();
                checkValue(testNames[e.test], "we", 32'(e.pkt.we), 32'(commit.we));
                checkValue(testNames[e.test], "rd", 32'(e.pkt.rd), 32'(commit.rd));
                checkValue(testNames[e.test], "data", 32'(e.pkt.data), 32'(commit.data));
            end
        end
    end

    initial begin
        stepS step;
        int   drain;
        rstN  = 1'b0;
        fetch = '0;
        for (int i = 0; i < backendPkg::ARCH_REGS; i++) begin
            archRegs[i] = '0;
        end
        loadPrograms();
        cycleLimit = 20 * progQ.size() + 200;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(posedge clk);
        #1;
        checkValue("resetRead", "stall", 32'd0, 32'(stall));
        checkValue("resetRead", "commit.valid", 32'd0, 32'(commit.valid));
        foreach (progQ[i]) begin
            step = progQ[i];
            while (stall) begin
                @(posedge clk);
                #1;
            end
            fetch = '{valid: 1'b1, inst: step.inst};
            modelStep(step.inst, step.test);
            @(posedge clk);
            #1;
            fetch.valid = 1'b0;
            repeat (step.gap) begin
                @(posedge clk);
                #1;
            end
        end
        drain = 0;
        while (expQ.size() != 0 && drain < 200) begin
            @(posedge clk);
            drain++;
        end
        repeat (10) @(posedge clk);
        if (expQ.size() != 0) begin
            errorCount++;
            $display("%0d expected commits never arrived", expQ.size());
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
backendPkg.sv
decode.sv
rename.sv
rob.sv
intIssueQueue.sv
execute.sv
backend.sv
backend_asserts.sv
backendTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= backendTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
